// File: mcu_cmd_pkg.sv
package mcu_cmd_pkg;

   ////////////////////////////////////////////////////////////
   // command byte codes
   ////////////////////////////////////////////////////////////

   // load the pointer from two parameter bytes, high byte first
   localparam logic [7:0] CMD_SET_ADDR = 8'h10;
   // store each parameter byte at the pointer
   localparam logic [7:0] CMD_WRITE    = 8'h20;
   // return the byte at the pointer for each parameter byte
   localparam logic [7:0] CMD_READ     = 8'h30;
   // return the pointer, high byte first
   localparam logic [7:0] CMD_GET_ADDR = 8'h40;

   // shifted out while the command byte comes in
   localparam logic [7:0] SPI_DUMMY_BYTE = 8'h5A;

   ////////////////////////////////////////////////////////////
   // structs between the blocks
   ////////////////////////////////////////////////////////////

   // received bytes and strobes from the spi slave, 45 bits
   typedef struct packed {
      logic [8:0]  reserved;
      logic        cmd_ready;
      logic        param_ready;
      logic [7:0]  cmd_data;
      logic [7:0]  param_data;
      logic        startmessage;
      logic        endmessage;
      logic [15:0] byte_cnt;
   } spi_rx_t;

   // one access to the byte memory, 26 bits
   typedef struct packed {
      logic        we;
      logic        re;
      logic [15:0] addr;
      logic [7:0]  wdata;
   } mem_req_t;

endpackage

// File: spi_slave.sv
`timescale 1ns/1ps

module spi_slave import mcu_cmd_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       sck,
   input  logic       mosi,
   input  logic       ssel,
   input  logic [7:0] reply_data,
   output logic       miso,
   output logic       miso_oe,
   output spi_rx_t    rx
);

   logic [2:0]  sck_sync;
   logic [2:0]  ssel_sync;
   logic [1:0]  mosi_sync;
   logic        sck_rise;
   logic        sck_fall;
   logic        ssel_active;
   logic        msg_start;
   logic        msg_end;
   logic [2:0]  bit_cnt;
   logic [15:0] byte_cnt;
   logic [7:0]  rx_shift;
   logic [7:0]  tx_shift;
   logic        byte_done;
   logic        cmd_pend;
   logic        param_pend;
   logic [7:0]  byte_q;
   logic [15:0] idx_q;

   ////////////////////////////////////////////////////////////
   // pin synchronizers
   ////////////////////////////////////////////////////////////

   // sck idles low and ssel idles high in mode 0
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sck_sync  <= '0;
         ssel_sync <= '1;
         mosi_sync <= '0;
      end else begin
         sck_sync  <= {sck_sync[1:0], sck};
         ssel_sync <= {ssel_sync[1:0], ssel};
         mosi_sync <= {mosi_sync[0], mosi};
      end
   end

   // edges seen on the two older stages
   assign sck_rise    = (sck_sync[2:1] == 2'b01);
   assign sck_fall    = (sck_sync[2:1] == 2'b10);
   // ssel active low
   assign ssel_active = ~ssel_sync[1];
   assign msg_start   = (ssel_sync[2:1] == 2'b10);
   assign msg_end     = (ssel_sync[2:1] == 2'b01);

   ////////////////////////////////////////////////////////////
   // receive side
   ////////////////////////////////////////////////////////////

   // bit and byte counters held at zero outside a message
   always_ff @(posedge clk) begin
      if (!rst_n || !ssel_active) begin
         bit_cnt  <= '0;
         byte_cnt <= '0;
      end else begin
         if (sck_rise)
            bit_cnt <= bit_cnt + 3'd1;
         if (byte_done)
            byte_cnt <= byte_cnt + 16'd1;
      end
   end

   // msb first, sampled on sck rise
   always_ff @(posedge clk) begin
      if (ssel_active && sck_rise)
         rx_shift <= {rx_shift[6:0], mosi_sync[1]};
   end

   // byte complete flag, then sort into command or parameter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         byte_done  <= 1'b0;
         cmd_pend   <= 1'b0;
         param_pend <= 1'b0;
      end else begin
         byte_done  <= ssel_active && sck_rise && (bit_cnt == 3'd7);
         cmd_pend   <= byte_done && (byte_cnt == 16'd0);
         param_pend <= byte_done && (byte_cnt != 16'd0);
      end
   end

   // byte and its index ride along with the pending flags
   always_ff @(posedge clk) begin
      byte_q <= rx_shift;
      idx_q  <= byte_cnt;
   end

   // output register stage toward the decoder
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx <= '0;
      end else begin
         rx.reserved     <= '0;
         rx.cmd_ready    <= cmd_pend;
         rx.param_ready  <= param_pend;
         rx.startmessage <= msg_start;
         rx.endmessage   <= msg_end;
         if (msg_start)
            rx.cmd_data <= 8'h00;
         else if (cmd_pend)
            rx.cmd_data <= byte_q;
         if (param_pend)
            rx.param_data <= byte_q;
         if (cmd_pend || param_pend)
            rx.byte_cnt <= idx_q;
      end
   end

   ////////////////////////////////////////////////////////////
   // transmit side
   ////////////////////////////////////////////////////////////

   // dummy byte first, reply byte at the fall that opens each later byte
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_shift <= '0;
      end else if (ssel_active) begin
         if (msg_start)
            tx_shift <= SPI_DUMMY_BYTE;
         else if (sck_fall) begin
            if (bit_cnt == 3'd0)
               tx_shift <= reply_data;
            else
               tx_shift <= {tx_shift[6:0], 1'b0};
         end
      end
   end

   assign miso    = tx_shift[7];
   assign miso_oe = ssel_active;

   // one strobe per received byte
   a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
      !(rx.cmd_ready && rx.param_ready));

endmodule

// File: mcu_cmd_decoder.sv
`timescale 1ns/1ps

module mcu_cmd_decoder import mcu_cmd_pkg::*; #(
   parameter int ADDR_W = 10
) (
   input  logic       clk,
   input  logic       rst_n,
   input  spi_rx_t    rx,
   input  logic [7:0] rdata,
   output logic [7:0] reply_data,
   output mem_req_t   mem_req
);

   logic [7:0]        cmd_q;
   logic [ADDR_W-1:0] ptr;
   logic [15:0]       ptr_ext;
   logic              rd_pend;
   logic              is_rd;
   logic              is_wr;

   // pointer seen as a 16 bit address
   assign ptr_ext = 16'(ptr);

   ////////////////////////////////////////////////////////////
   // memory request
   ////////////////////////////////////////////////////////////

   // read at the command byte and at each later byte of a read
   assign is_rd = (rx.cmd_ready && (rx.cmd_data == CMD_READ))
                || (rx.param_ready && (cmd_q == CMD_READ));
   // write only on parameter bytes
   assign is_wr = rx.param_ready && (cmd_q == CMD_WRITE);

   always_comb begin
      mem_req       = '0;
      mem_req.we    = is_wr;
      mem_req.re    = is_rd;
      mem_req.addr  = ptr_ext;
      mem_req.wdata = rx.param_data;
   end

   ////////////////////////////////////////////////////////////
   // command state, pointer and reply
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_q      <= '0;
         ptr        <= '0;
         rd_pend    <= 1'b0;
         reply_data <= '0;
      end else begin
         // read data lands one clk after re
         rd_pend <= is_rd;
         if (rd_pend)
            reply_data <= rdata;

         if (rx.startmessage || rx.endmessage) begin
            cmd_q <= '0;
         end else if (rx.cmd_ready) begin
            cmd_q <= rx.cmd_data;
            // read reply comes from the memory path
            if (rx.cmd_data == CMD_GET_ADDR)
               reply_data <= ptr_ext[15:8];
            else if (rx.cmd_data != CMD_READ)
               reply_data <= 8'h00;
         end else if (rx.param_ready) begin
            case (cmd_q)
               CMD_SET_ADDR: begin
                  // high byte first, upper bits fall off for small memories
                  if (rx.byte_cnt == 16'd1)
                     ptr <= ADDR_W'({rx.param_data, ptr_ext[7:0]});
                  else if (rx.byte_cnt == 16'd2)
                     ptr <= ADDR_W'({ptr_ext[15:8], rx.param_data});
                  reply_data <= 8'h00;
               end
               CMD_READ: begin
                  // reply follows rd_pend
               end
               CMD_GET_ADDR: begin
                  if (rx.byte_cnt == 16'd1)
                     reply_data <= ptr_ext[7:0];
                  else
                     reply_data <= 8'h00;
               end
               default: begin
                  reply_data <= 8'h00;
               end
            endcase
         end

         // post increment, wraps at the memory size
         if (is_wr || is_rd)
            ptr <= ptr + 1'b1;
      end
   end

   a_we_re_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(mem_req.we && mem_req.re));

endmodule

// File: mcu_byte_mem.sv
`timescale 1ns/1ps

module mcu_byte_mem import mcu_cmd_pkg::*; #(
   parameter int ADDR_W = 10
) (
   input  logic       clk,
   input  logic       rst_n,
   input  mem_req_t   mem_req,
   output logic [7:0] rdata
);

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////

   localparam int DEPTH = 1 << ADDR_W;

   logic [7:0]        mem [DEPTH];
   logic [ADDR_W-1:0] idx;

   // only the low ADDR_W bits select a byte
   assign idx = mem_req.addr[ADDR_W-1:0];

   // write port
   always_ff @(posedge clk) begin
      if (mem_req.we)
         mem[idx] <= mem_req.wdata;
   end

   ////////////////////////////////////////////////////////////
   // read port
   ////////////////////////////////////////////////////////////

   // one clk latency, holds between reads
   always_ff @(posedge clk) begin
      if (!rst_n)
         rdata <= '0;
      else if (mem_req.re)
         rdata <= mem[idx];
   end

   // the decoder pointer never reaches past the array
   a_addr_range : assert property (@(posedge clk) disable iff (!rst_n)
      (mem_req.we || mem_req.re) |-> ((mem_req.addr >> ADDR_W) == 16'd0));

endmodule

// File: mcu_cmd_top.sv
`timescale 1ns/1ps

module mcu_cmd_top import mcu_cmd_pkg::*; #(
   parameter int ADDR_W = 10
) (
   input  logic clk,
   input  logic rst_n,
   input  logic sck,
   input  logic mosi,
   input  logic ssel,
   output logic miso,
   output logic miso_oe
);

   spi_rx_t    rx;
   logic [7:0] reply_data;
   mem_req_t   mem_req;
   logic [7:0] rdata;

   // pins to bytes and strobes
   spi_slave i_spi_slave (
      .clk        (clk),
      .rst_n      (rst_n),
      .sck        (sck),
      .mosi       (mosi),
      .ssel       (ssel),
      .reply_data (reply_data),
      .miso       (miso),
      .miso_oe    (miso_oe),
      .rx         (rx)
   );

   // command handling and address pointer
   mcu_cmd_decoder #(.ADDR_W(ADDR_W)) i_mcu_cmd_decoder (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .rdata      (rdata),
      .reply_data (reply_data),
      .mem_req    (mem_req)
   );

   // on-chip byte store
   mcu_byte_mem #(.ADDR_W(ADDR_W)) i_mcu_byte_mem (
      .clk     (clk),
      .rst_n   (rst_n),
      .mem_req (mem_req),
      .rdata   (rdata)
   );

endmodule

// File: tb_mcu_cmd.sv
`timescale 1ns/1ps

module tb_mcu_cmd;

   localparam int ADDR_W     = 10;
   localparam int MEM_SIZE   = 1 << ADDR_W;
   // spi half period and idle gap, in clk
   localparam int HALF_CLKS  = 10;
   localparam int GAP_CLKS   = 10;
   localparam int OE_TIMEOUT = 20;

   localparam logic [7:0] OP_SET_ADDR = 8'h10;
   localparam logic [7:0] OP_WRITE    = 8'h20;
   localparam logic [7:0] OP_READ     = 8'h30;
   localparam logic [7:0] OP_GET_ADDR = 8'h40;
   localparam logic [7:0] OP_UNKNOWN  = 8'h77;
   localparam logic [7:0] DUMMY_REPLY = 8'h5A;

   logic clk;
   logic rst_n;
   logic sck;
   logic mosi;
   logic ssel;
   logic miso;
   logic miso_oe;

   // bytes of the current message, out and back
   logic [7:0]        tx_bytes [$];
   logic [7:0]        rx_bytes [$];
   // reference memory and pointer
   logic [7:0]        ref_mem [MEM_SIZE];
   logic [ADDR_W-1:0] ref_ptr;
   logic [31:0]       rng_state;
   int                errors;
   int                checks;

   mcu_cmd_top #(.ADDR_W(ADDR_W)) i_mcu_cmd_top (
      .clk     (clk),
      .rst_n   (rst_n),
      .sck     (sck),
      .mosi    (mosi),
      .ssel    (ssel),
      .miso    (miso),
      .miso_oe (miso_oe)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = next_rand();
      return r[23:16];
   endfunction

   // n edges, then to the drive point 2 ns after
   task automatic step_clks(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   // bounded wait for the output enable to settle
   task automatic wait_oe(input logic level);
      int cnt;
      cnt = 0;
      while (miso_oe !== level && cnt < OE_TIMEOUT) begin
         step_clks(1);
         cnt++;
      end
      if (miso_oe !== level) begin
         $display("timeout: miso_oe did not reach %0b within %0d clocks at %0t",
                  level, OE_TIMEOUT, $time);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // spi mode 0 master
   ////////////////////////////////////////////////////////////

   task automatic spi_message();
      logic [7:0] cur;
      logic [7:0] shift_in;
      int         b;
      int         i;
      rx_bytes.delete();
      shift_in = 8'h00;
      ssel = 1'b0;
      wait_oe(1'b1);
      for (b = 0; b < tx_bytes.size(); b++) begin
         cur = tx_bytes[b];
         for (i = 0; i < 8; i++) begin
            // msb first, mosi changes with sck low
            mosi = cur[7];
            cur = {cur[6:0], 1'b0};
            step_clks(HALF_CLKS);
            // mid-bit sample of enable and data
            checks++;
            if (miso_oe !== 1'b1) begin
               $display("FAIL %0t: miso_oe low inside message, byte %0d", $time, b);
               errors++;
            end
            shift_in = {shift_in[6:0], miso};
            sck = 1'b1;
            step_clks(HALF_CLKS);
            sck = 1'b0;
         end
         rx_bytes.push_back(shift_in);
      end
      step_clks(HALF_CLKS);
      ssel = 1'b1;
      wait_oe(1'b0);
      step_clks(GAP_CLKS);
      checks++;
      if (miso_oe !== 1'b0) begin
         $display("FAIL %0t: miso_oe high between messages", $time);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   // reply at one position, from the pointer at message start
   function automatic logic [7:0] expected_reply(input logic [7:0] cmd, input int pos,
                                                 input logic [ADDR_W-1:0] ptr_start);
      logic [7:0]        val;
      logic [15:0]       ptr16;
      logic [ADDR_W-1:0] idx;
      val = 8'h00;
      ptr16 = 16'(ptr_start);
      if (pos == 0) begin
         val = DUMMY_REPLY;
      end else if (cmd == OP_READ) begin
         idx = ADDR_W'((int'(ptr_start) + pos - 1) % MEM_SIZE);
         val = ref_mem[idx];
      end else if (cmd == OP_GET_ADDR) begin
         if (pos == 1)
            val = ptr16[15:8];
         else if (pos == 2)
            val = ptr16[7:0];
      end
      return val;
   endfunction

   task automatic update_model();
      int i;
      case (tx_bytes[0])
         OP_SET_ADDR: begin
            if (tx_bytes.size() >= 3)
               ref_ptr = ADDR_W'(((int'(tx_bytes[1]) << 8) | int'(tx_bytes[2])) % MEM_SIZE);
         end
         OP_WRITE: begin
            for (i = 1; i < tx_bytes.size(); i++) begin
               ref_mem[ref_ptr] = tx_bytes[i];
               ref_ptr = ADDR_W'((int'(ref_ptr) + 1) % MEM_SIZE);
            end
         end
         OP_READ: begin
            // one read per byte clocked in, the command byte too
            ref_ptr = ADDR_W'((int'(ref_ptr) + tx_bytes.size()) % MEM_SIZE);
         end
         default: begin
            // unknown codes touch nothing
         end
      endcase
   endtask

   task automatic check_message();
      logic [7:0] exp;
      int         pos;
      for (pos = 0; pos < tx_bytes.size(); pos++) begin
         exp = expected_reply(tx_bytes[0], pos, ref_ptr);
         checks++;
         if (rx_bytes[pos] !== exp) begin
            $display("FAIL %0t: cmd %02h pos %0d expected %02h got %02h",
                     $time, tx_bytes[0], pos, exp, rx_bytes[pos]);
            errors++;
         end
      end
   endtask

   task automatic run_message();
      spi_message();
      check_message();
      update_model();
   endtask

   ////////////////////////////////////////////////////////////
   // message builders
   ////////////////////////////////////////////////////////////

   task automatic set_addr(input int addr);
      tx_bytes.delete();
      tx_bytes.push_back(OP_SET_ADDR);
      tx_bytes.push_back(8'(addr >> 8));
      tx_bytes.push_back(8'(addr));
      run_message();
   endtask

   task automatic get_addr();
      tx_bytes.delete();
      tx_bytes.push_back(OP_GET_ADDR);
      repeat (3) tx_bytes.push_back(8'h00);
      run_message();
   endtask

   // command then len random bytes, data or don't care
   task automatic burst(input logic [7:0] cmd, input int len);
      tx_bytes.delete();
      tx_bytes.push_back(cmd);
      repeat (len) tx_bytes.push_back(rand_byte());
      run_message();
   endtask

   task automatic write_read_burst(input int base, input int len);
      set_addr(base);
      burst(OP_WRITE, len);
      set_addr(base);
      burst(OP_READ, len);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int base;
      int len;
      int k;
      rng_state = 32'd20;
      errors = 0;
      checks = 0;
      ref_ptr = '0;
      rst_n = 1'b0;
      sck = 1'b0;
      mosi = 1'b0;
      ssel = 1'b1;
      step_clks(4);
      rst_n = 1'b1;
      step_clks(GAP_CLKS);
      checks++;
      if (miso_oe !== 1'b0) begin
         $display("FAIL %0t: miso_oe high after reset", $time);
         errors++;
      end

      // pointer load and read back
      for (k = 0; k < 4; k++) begin
         base = int'(next_rand() >> 8) & (MEM_SIZE - 1);
         set_addr(base);
         get_addr();
      end

      // random bursts
      for (k = 0; k < 3; k++) begin
         base = int'(next_rand() >> 8) & (MEM_SIZE - 1);
         len = 1 + int'(next_rand() >> 8) % 12;
         write_read_burst(base, len);
      end

      // burst across the top address
      write_read_burst(MEM_SIZE - 3, 8);

      // unknown command between pointer load and read back
      set_addr(MEM_SIZE - 3);
      burst(OP_UNKNOWN, 4);
      get_addr();
      burst(OP_READ, 8);

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: build.f
mcu_cmd_pkg.sv
spi_slave.sv
mcu_cmd_decoder.sv
mcu_byte_mem.sv
mcu_cmd_top.sv
tb_mcu_cmd.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the command interface testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_mcu_cmd -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
   exit 0
fi
exit 1
